//--- rv_isa_pkg.sv
// RV32 base encoding only; compressed instructions are not recognized and decode as op_other
package rv_isa_pkg;

    localparam int inst_width = 32; // RV32 instruction word

    // major opcode field position
    localparam int opcode_lsb = 0;
    localparam int opcode_msb = 6;

    // only the control-flow opcodes matter to the frontend
    typedef enum logic [6:0] {
        op_branch = 7'b1100011, // BEQ/BNE/BLT/BGE/BLTU/BGEU
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_other  = 7'b0000000  // anything that is not control flow
    } opcode_e;

    // immediate sign bit, shared by the J and B formats
    localparam int imm_sign_bit = 31;

endpackage

//--- fetch_pkg.sv
// fetch addresses are 32-bit byte addresses with word-aligned instructions
package fetch_pkg;

    localparam int xlen = 32;       // address width
    localparam int word_bytes = 4;  // byte step between instruction words

    typedef logic [xlen-1:0] addr_t;
    typedef logic [31:0] inst_t;

    // four-phase memory port handshake
    typedef enum logic [1:0] {
        st_idle,    // req low, may start a request
        st_req,     // req high, waiting for ack
        st_release  // req dropped, waiting for ack to fall
    } port_state_e;

endpackage

//--- pc_gen.sv
// redirect targets are forced to word alignment; redirect wins over a same-cycle line update
`timescale 1ns/1ps

module pc_gen #(
    parameter fetch_pkg::addr_t reset_pc = 32'h0000_0100
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             redir,
    input  fetch_pkg::addr_t redir_pc,
    input  logic             line_valid,
    input  fetch_pkg::addr_t next_pc,
    output fetch_pkg::addr_t fetch_pc
);

    localparam int align_bits = $clog2(fetch_pkg::word_bytes);

    fetch_pkg::addr_t pc_q;
    fetch_pkg::addr_t redir_aligned;

    assign redir_aligned = {redir_pc[fetch_pkg::xlen-1:align_bits], {align_bits{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= reset_pc;
        end else if (redir) begin
            pc_q <= redir_aligned; // backend redirect first
        end else if (line_valid) begin
            pc_q <= next_pc;       // predicted fall-through or target
        end
    end

    assign fetch_pc = pc_q;

    // a misaligned PC would break every slot index downstream
    pc_aligned_a: assert property (@(posedge clk) disable iff (rst)
        fetch_pc[align_bits-1:0] == '0)
        else $error("fetch_pc lost word alignment: %h", fetch_pc);

endmodule

//--- imem_port.sv
// one line outstanding at a time; a redirect during a request lets the handshake finish and drops its data
`timescale 1ns/1ps

module imem_port #(
    parameter int line_words = 4
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  fetch_pkg::addr_t                            fetch_pc,
    input  logic                                        room,
    input  logic                                        redir,
    output logic                                        ic_req,
    output fetch_pkg::addr_t                            ic_addr,
    input  logic                                        ic_ack,
    input  logic [line_words*rv_isa_pkg::inst_width-1:0] ic_rdata,
    output logic                                        line_valid,
    output fetch_pkg::addr_t                            line_pc,
    output logic [line_words*rv_isa_pkg::inst_width-1:0] line_data
);

    localparam int off_bits = $clog2(line_words * fetch_pkg::word_bytes);

    fetch_pkg::port_state_e state;
    fetch_pkg::addr_t       req_pc;  // PC latched at request start
    logic                   stale;   // response belongs to a flushed path
    logic                   start_req;
    logic                   capture;

    assign start_req = (state == fetch_pkg::st_idle) && room && !ic_ack;
    assign capture   = (state == fetch_pkg::st_req) && ic_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= fetch_pkg::st_idle;
            ic_req     <= 1'b0;
            line_valid <= 1'b0;
            stale      <= 1'b0;
        end else begin
            line_valid <= 1'b0; // single-cycle pulse
            case (state)
                fetch_pkg::st_idle: begin
                    if (start_req) begin
                        state  <= fetch_pkg::st_req;
                        ic_req <= 1'b1;
                        stale  <= redir; // PC latched this edge is already old
                    end
                end
                fetch_pkg::st_req: begin
                    if (redir) begin
                        stale <= 1'b1;
                    end
                    if (ic_ack) begin
                        state      <= fetch_pkg::st_release;
                        ic_req     <= 1'b0;
                        line_valid <= !(stale || redir);
                    end
                end
                fetch_pkg::st_release: begin
                    if (!ic_ack) begin
                        state <= fetch_pkg::st_idle; // four-phase done
                    end
                end
                default: state <= fetch_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_req) begin
            req_pc <= fetch_pc;
        end
        if (capture) begin
            line_data <= ic_rdata;
        end
    end

    assign ic_addr = {req_pc[fetch_pkg::xlen-1:off_bits], {off_bits{1'b0}}};
    assign line_pc = req_pc; // word offset kept for predecode

    req_held_a: assert property (@(posedge clk) disable iff (rst)
        $fell(ic_req) |-> $past(ic_ack))
        else $error("ic_req dropped before ic_ack");

    addr_stable_a: assert property (@(posedge clk) disable iff (rst)
        ic_req && $past(ic_req) |-> $stable(ic_addr))
        else $error("ic_addr changed while ic_req high");

endmodule

//--- predecode.sv
// static rule only: JAL and backward branches taken, JALR and forward branches fall through
`timescale 1ns/1ps

module predecode #(
    parameter int line_words = 4
) (
    input  logic                                         line_valid,
    input  fetch_pkg::addr_t                             line_pc,
    input  logic [line_words*rv_isa_pkg::inst_width-1:0] line_data,
    output logic [line_words-1:0]                        keep_mask,
    output fetch_pkg::addr_t [line_words-1:0]            slot_pc,
    output fetch_pkg::inst_t [line_words-1:0]            slot_inst,
    output fetch_pkg::addr_t                             next_pc
);

    localparam int off_bits   = $clog2(line_words * fetch_pkg::word_bytes);
    localparam int align_bits = $clog2(fetch_pkg::word_bytes);
    localparam int idx_bits   = $clog2(line_words);
    localparam int iw         = rv_isa_pkg::inst_width;
    localparam int sb         = rv_isa_pkg::imm_sign_bit;

    fetch_pkg::addr_t       line_base;
    logic [idx_bits-1:0]    start_idx;
    rv_isa_pkg::opcode_e    op [line_words];
    logic [line_words-1:0]  taken;
    fetch_pkg::addr_t       target [line_words];
    logic                   taken_seen;

    assign line_base = {line_pc[fetch_pkg::xlen-1:off_bits], {off_bits{1'b0}}};
    assign start_idx = line_pc[off_bits-1:align_bits]; // first slot on the fetch path

    // per-slot decode and target computation
    always_comb begin
        for (int i = 0; i < line_words; i++) begin
            slot_inst[i] = line_data[i*iw +: iw];
            slot_pc[i]   = line_base + fetch_pkg::addr_t'(i * fetch_pkg::word_bytes);
            case (slot_inst[i][rv_isa_pkg::opcode_msb:rv_isa_pkg::opcode_lsb])
                rv_isa_pkg::op_branch: op[i] = rv_isa_pkg::op_branch;
                rv_isa_pkg::op_jal:    op[i] = rv_isa_pkg::op_jal;
                rv_isa_pkg::op_jalr:   op[i] = rv_isa_pkg::op_jalr; // no target known here
                default:               op[i] = rv_isa_pkg::op_other;
            endcase
            // negative B offset means a loop back edge
            taken[i] = (op[i] == rv_isa_pkg::op_jal) ||
                       (op[i] == rv_isa_pkg::op_branch && slot_inst[i][sb]);
            if (op[i] == rv_isa_pkg::op_jal) begin
                target[i] = slot_pc[i] + {{(fetch_pkg::xlen-20){slot_inst[i][sb]}},
                    slot_inst[i][19:12], slot_inst[i][20], slot_inst[i][30:21], 1'b0};
            end else begin
                target[i] = slot_pc[i] + {{(fetch_pkg::xlen-12){slot_inst[i][sb]}},
                    slot_inst[i][7], slot_inst[i][30:25], slot_inst[i][11:8], 1'b0};
            end
        end
    end

    // keep from the entry slot up to the first taken one
    always_comb begin
        taken_seen = 1'b0;
        keep_mask  = '0;
        next_pc    = line_base + fetch_pkg::addr_t'(line_words * fetch_pkg::word_bytes);
        for (int i = 0; i < line_words; i++) begin
            if (line_valid && idx_bits'(i) >= start_idx && !taken_seen) begin
                keep_mask[i] = 1'b1;
                if (taken[i]) begin
                    taken_seen = 1'b1;
                    next_pc    = target[i];
                end
            end
        end
    end

endmodule

//--- fetch_queue.sv
// fq_depth and line_words must be powers of two with fq_depth >= line_words; redirect drops all entries
`timescale 1ns/1ps

module fetch_queue #(
    parameter int line_words = 4,
    parameter int fq_depth   = 8
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              redir,
    input  logic [line_words-1:0]             keep_mask,
    input  fetch_pkg::addr_t [line_words-1:0] slot_pc,
    input  fetch_pkg::inst_t [line_words-1:0] slot_inst,
    output logic                              room,
    output logic                              out_valid,
    input  logic                              out_ready,
    output fetch_pkg::addr_t                  out_pc,
    output fetch_pkg::inst_t                  out_inst
);

    localparam int ptr_w = $clog2(fq_depth);
    localparam int cnt_w = ptr_w + 1;

    fetch_pkg::addr_t pc_mem   [fq_depth];
    fetch_pkg::inst_t inst_mem [fq_depth];

    logic [ptr_w-1:0] head;
    logic [ptr_w-1:0] tail;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] push_cnt;
    logic [ptr_w-1:0] wr_idx [line_words];
    logic             pop;

    // pack kept slots densely onto the tail
    always_comb begin
        push_cnt = '0;
        for (int i = 0; i < line_words; i++) begin
            wr_idx[i] = tail + ptr_w'(push_cnt);
            push_cnt  = push_cnt + cnt_w'(keep_mask[i]);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < line_words; i++) begin
            if (keep_mask[i]) begin
                pc_mem[wr_idx[i]]   <= slot_pc[i];
                inst_mem[wr_idx[i]] <= slot_inst[i];
            end
        end
    end

    assign pop = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst || redir) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + ptr_w'(pop);
            tail  <= tail + ptr_w'(push_cnt);
            count <= count + push_cnt - cnt_w'(pop);
        end
    end

    assign out_valid = count != '0;
    assign out_pc    = pc_mem[head];
    assign out_inst  = inst_mem[head];
    assign room      = (cnt_w'(fq_depth) - count) >= cnt_w'(line_words); // a whole line fits

    count_bound_a: assert property (@(posedge clk) disable iff (rst)
        count <= cnt_w'(fq_depth))
        else $error("fetch queue overflow, count %0d", count);

endmodule

//--- frontend_top.sv
// line_words >= 2 and fq_depth >= line_words, both powers of two; memory port must follow four-phase req/ack
`timescale 1ns/1ps

module frontend_top #(
    parameter int               line_words = 4,
    parameter int               fq_depth   = 8,
    parameter fetch_pkg::addr_t reset_pc   = 32'h0000_0100
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         redir,
    input  fetch_pkg::addr_t                             redir_pc,
    output logic                                         ic_req,
    output fetch_pkg::addr_t                             ic_addr,
    input  logic                                         ic_ack,
    input  logic [line_words*rv_isa_pkg::inst_width-1:0] ic_rdata,
    output logic                                         out_valid,
    input  logic                                         out_ready,
    output fetch_pkg::addr_t                             out_pc,
    output fetch_pkg::inst_t                             out_inst
);

    fetch_pkg::addr_t                             fetch_pc;
    fetch_pkg::addr_t                             next_pc;
    fetch_pkg::addr_t                             line_pc;
    logic                                         line_valid;
    logic [line_words*rv_isa_pkg::inst_width-1:0] line_data;
    logic [line_words-1:0]                        keep_mask;
    fetch_pkg::addr_t [line_words-1:0]            slot_pc;
    fetch_pkg::inst_t [line_words-1:0]            slot_inst;
    logic                                         room;

    pc_gen #(.reset_pc(reset_pc)) pc_gen_i (
        .clk(clk), .rst(rst), .redir(redir), .redir_pc(redir_pc),
        .line_valid(line_valid), .next_pc(next_pc), .fetch_pc(fetch_pc)
    );

    imem_port #(.line_words(line_words)) imem_port_i (
        .clk(clk), .rst(rst), .fetch_pc(fetch_pc), .room(room), .redir(redir),
        .ic_req(ic_req), .ic_addr(ic_addr), .ic_ack(ic_ack), .ic_rdata(ic_rdata),
        .line_valid(line_valid), .line_pc(line_pc), .line_data(line_data)
    );

    predecode #(.line_words(line_words)) predecode_i (
        .line_valid(line_valid), .line_pc(line_pc), .line_data(line_data),
        .keep_mask(keep_mask), .slot_pc(slot_pc), .slot_inst(slot_inst), .next_pc(next_pc)
    );

    fetch_queue #(.line_words(line_words), .fq_depth(fq_depth)) fetch_queue_i (
        .clk(clk), .rst(rst), .redir(redir),
        .keep_mask(keep_mask), .slot_pc(slot_pc), .slot_inst(slot_inst), .room(room),
        .out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc), .out_inst(out_inst)
    );

endmodule

//--- tb_clock_gen.sv
// free-running clock; reset held high for rst_cycles rising edges, released 2 ns after an edge
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns  = 40,
    parameter int rst_cycles = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        #2;
        rst = 1'b0; // synchronous release, away from the edge
    end

endmodule

//--- frontend_tb.sv
// default parameters (4-word lines, 8 entries, reset at 0x100); frontend_patterns.mem read from run dir
`timescale 1ns/1ps

module frontend_tb;

    localparam int               line_words = 4;
    localparam int               fq_depth   = 8;
    localparam fetch_pkg::addr_t reset_pc   = 32'h0000_0100;

    logic                     clk;
    logic                     rst;
    logic                     redir;
    fetch_pkg::addr_t         redir_pc;
    logic                     ic_req;
    fetch_pkg::addr_t         ic_addr;
    logic                     ic_ack;
    logic [line_words*32-1:0] ic_rdata;
    logic                     out_valid;
    logic                     out_ready;
    fetch_pkg::addr_t         out_pc;
    fetch_pkg::inst_t         out_inst;

    logic [31:0] prog [logic [31:0]]; // sparse program image
    logic [31:0] pat [0:191];
    int          r_kind [$];
    int          r_after [$];
    logic [31:0] r_target [$];
    int          ridx = 0;
    int          total_items = 0;
    int          items = 0;
    int          checks = 0;
    int          errors = 0;
    logic        timed_out = 1'b0;
    logic [31:0] exp_pc = reset_pc; // reference walk position

    tb_clock_gen #(.period_ns(40), .rst_cycles(4)) clock_i (.clk(clk), .rst(rst));

    frontend_top #(
        .line_words(line_words), .fq_depth(fq_depth), .reset_pc(reset_pc)
    ) frontend_top_i (
        .clk(clk), .rst(rst), .redir(redir), .redir_pc(redir_pc),
        .ic_req(ic_req), .ic_addr(ic_addr), .ic_ack(ic_ack), .ic_rdata(ic_rdata),
        .out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc), .out_inst(out_inst)
    );

    // unlisted words are addi x1 with an immediate folded from the whole address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] fold;
        if (prog.exists(addr)) return prog[addr];
        fold = addr ^ (addr >> 12) ^ (addr >> 24);
        return {fold[11:0], 5'd0, 3'b000, 5'd1, 7'b0010011};
    endfunction

    // jal and backward branches taken, all else falls through
    function automatic logic [31:0] walk_next(input logic [31:0] pc, input logic [31:0] inst);
        logic [6:0]  op;
        logic [31:0] j_off;
        logic [31:0] b_off;
        op    = inst[rv_isa_pkg::opcode_msb:rv_isa_pkg::opcode_lsb];
        j_off = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        b_off = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        if (op == rv_isa_pkg::op_jal) return pc + j_off;
        if (op == rv_isa_pkg::op_branch && inst[31]) return pc + b_off;
        return pc + 4;
    endfunction

    task automatic load_patterns();
        int i;
        $readmemh("frontend_patterns.mem", pat);
        i = 0;
        while (i < 190 && total_items == 0) begin
            case (pat[i])
                32'd0: prog[pat[i+1]] = pat[i+2];
                32'd1, 32'd2: begin
                    r_kind.push_back(int'(pat[i]));
                    r_after.push_back(int'(pat[i+1]));
                    r_target.push_back(pat[i+2]);
                end
                32'd3: total_items = int'(pat[i+1]);
                default: ;
            endcase
            i += 3;
        end
    endtask

    task automatic check_item();
        logic [31:0] exp_inst;
        exp_inst = mem_word(exp_pc);
        checks++;
        assert (out_pc == exp_pc) else begin
            errors++;
            $display("mismatch at %0t: out_pc %h, expected %h", $time, out_pc, exp_pc);
        end
        assert (out_inst == exp_inst) else begin
            errors++;
            $display("mismatch at %0t: out_inst %h at pc %h, expected %h",
                $time, out_inst, exp_pc, exp_inst);
        end
        exp_pc = walk_next(exp_pc, exp_inst);
        items++;
    endtask

    // drives ready and redirects and checks each transfer at the falling edge
    task automatic run_items();
        logic after_redir;
        logic fire;
        after_redir = 1'b0;
        @(negedge rst);
        while (items < total_items) begin
            @(posedge clk);
            #2;
            fire = ridx < r_kind.size();
            if (fire) fire = items >= r_after[ridx] && (r_kind[ridx] == 1 || ic_req);
            redir = fire;
            if (fire) begin
                redir_pc  = r_target[ridx];
                out_ready = 1'b0; // nothing transfers in the flush cycle
                exp_pc    = r_target[ridx];
                ridx++;
            end else begin
                out_ready = ($urandom % 4) != 0;
            end
            @(negedge clk);
            if (after_redir) begin
                assert (!out_valid) else begin
                    errors++;
                    $display("mismatch at %0t: out_valid high right after a redirect", $time);
                end
            end
            after_redir = fire;
            if (out_valid && out_ready) check_item();
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d, items %0d of %0d", checks, errors, items, total_items);
        if (errors == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    initial begin : main
        void'($urandom(32'h4ae40295));
        redir     = 1'b0;
        redir_pc  = '0;
        ic_ack    = 1'b0;
        ic_rdata  = '0;
        out_ready = 1'b0;
        load_patterns();
        if (total_items == 0) begin
            errors++;
            $display("pattern file could not be read or has no end record");
        end else begin
            run_items();
        end
        finish_run();
    end

    // four-phase memory with 0 to 3 idle cycles before ack and ack dropped after req falls
    initial begin : mem_model
        int          delay;
        logic [31:0] addr;
        @(negedge rst);
        forever begin
            @(negedge clk);
            if (ic_req && !ic_ack) begin
                addr  = ic_addr;
                delay = int'($urandom % 4);
                assert (addr[3:0] == 4'h0) else begin // 16-byte lines
                    errors++;
                    $display("request address %h at %0t is not line-aligned", addr, $time);
                end
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #2;
                assert (ic_req && ic_addr == addr) else begin
                    errors++;
                    $display("ic_req dropped or ic_addr changed before ic_ack at %0t", $time);
                end
                for (int w = 0; w < line_words; w++) begin
                    ic_rdata[w*32 +: 32] = mem_word(addr + 32'(w * 4));
                end
                ic_ack = 1'b1;
                do @(negedge clk); while (ic_req);
                @(posedge clk);
                #2;
                assert (!ic_req) else begin
                    errors++;
                    $display("ic_req raised again before ic_ack fell at %0t", $time);
                end
                ic_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (total_items != 0);
        repeat (total_items * 20) @(posedge clk);
        timed_out = 1'b1;
        $display("timeout: %0d of %0d items seen within %0d cycles",
            items, total_items, total_items * 20);
        finish_run();
    end

endmodule

//--- frontend_patterns.mem
// three hex words per record: kind, a, b. kind 0 program word (a address, b instruction),
// kind 1 redirect after a outputs to b, kind 2 same once a request is in flight, kind 3 end at a
00000000 00000124 0240006f // jal x0 +0x24, lands mid-line at 0x148
00000000 0000014c 00000463 // beq forward, falls through
00000000 00000150 00008067 // jalr, falls through
00000000 0000015c fe009ce3 // bne back to 0x154
00000000 0000021c 0e40006f // jal to 0x300
00000001 00000016 00000208 // leave the loop, mid-line target
00000002 00000022 00000404
00000002 00000032 00000150 // back into jalr and the loop
00000003 00000046 00000000 // 70 items in total

//--- filelist.f
rv_isa_pkg.sv
fetch_pkg.sv
pc_gen.sv
imem_port.sv
predecode.sv
fetch_queue.sv
frontend_top.sv
tb_clock_gen.sv
frontend_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the frontend testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f filelist.f --top-module frontend_tb -o frontend_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/frontend_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$log"; then
    exit 1
fi
exit 0
